// File: design/vwrite_consts.svh
`ifndef VWRITE_CONSTS_SVH
`define VWRITE_CONSTS_SVH

// staging buffer address, one word
`define VW_ADDR_W 10
// period and duty counters
`define VW_PER_W 8
`define VW_DATA_W 32
// burst length in beats
`define VW_LEN_W 8
`define VW_DELAY_W 6
`define VW_EXT_ADDR_W 32

`endif

// File: design/vwrite_pkg.sv
`include "vwrite_consts.svh"

package vwrite_pkg;

   // one address generator setup
   typedef struct packed {
      logic [`VW_ADDR_W-1:0]  start;
      logic [`VW_ADDR_W-1:0]  incr;
      logic [`VW_PER_W-1:0]   per;
      logic [`VW_PER_W-1:0]   duty;
      logic [`VW_ADDR_W-1:0]  iter;
      logic [`VW_ADDR_W-1:0]  shift;
      logic [`VW_DELAY_W-1:0] delay;
   } gen_cfg_t;

   typedef struct packed {
      logic [`VW_EXT_ADDR_W-1:0] ext_addr;
      logic [`VW_LEN_W-1:0]      length;
      logic                      enabled;
      gen_cfg_t                  gen;
   } write_cfg_t;

   typedef struct packed {
      logic                      cyc;
      logic                      stb;
      logic                      we;
      logic [`VW_EXT_ADDR_W-1:0] adr;
      logic [`VW_DATA_W-1:0]     dat;
   } wb_m2s_t;

   typedef struct packed {
      logic ack;
   } wb_s2m_t;

   // flat in plain mode, bank plus offset in ping-pong mode
   typedef union packed {
      logic [`VW_ADDR_W-1:0] flat;
      struct packed {
         logic                  bank;
         logic [`VW_ADDR_W-2:0] offset;
      } banked;
   } buf_addr_u;

   typedef struct packed {
      logic                  en;
      logic [`VW_ADDR_W-1:0] addr;
      logic [`VW_DATA_W-1:0] data;
   } buf_wr_t;

endpackage

// File: design/addr_gen.sv
`timescale 1ns/1ns
`include "vwrite_consts.svh"

module addr_gen
   import vwrite_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      start_i,
   input  gen_cfg_t  cfg_i,
   input  logic      ready_i,
   output logic      valid_o,
   output buf_addr_u addr_o,
   output logic      done_o
);

   gen_cfg_t               cfg_q;
   logic                   busy_q;
   logic                   done_q;
   logic [`VW_DELAY_W-1:0] dly_q;
   logic [`VW_PER_W-1:0]   step_q;
   logic [`VW_ADDR_W-1:0]  iter_q;
   logic [`VW_ADDR_W-1:0]  base_q;
   logic [`VW_ADDR_W-1:0]  addr_q;
   logic                   cfg_empty;
   logic                   walking;
   logic                   advance;

   assign cfg_empty = (cfg_i.per == '0) || (cfg_i.iter == '0);
   assign walking = busy_q && (dly_q == '0);
   // steps past the duty are walked but not presented
   assign valid_o = walking && (step_q < cfg_q.duty);
   assign advance = walking && (ready_i || !valid_o);
   assign addr_o.flat = addr_q;
   assign done_o = done_q;

   always_ff @(posedge clk) begin
      if (start_i) begin
         cfg_q <= cfg_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q <= 1'b0;
         done_q <= 1'b1;
         dly_q  <= '0;
         step_q <= '0;
         iter_q <= '0;
         base_q <= '0;
         addr_q <= '0;
      end else if (start_i) begin
         busy_q <= !cfg_empty;
         done_q <= cfg_empty;
         dly_q  <= cfg_i.delay;
         step_q <= '0;
         iter_q <= '0;
         base_q <= cfg_i.start;
         addr_q <= cfg_i.start;
      end else if (busy_q && (dly_q != '0)) begin
         dly_q <= dly_q - 1'b1;
      end else if (advance) begin
         if (step_q == cfg_q.per - 1'b1) begin
            step_q <= '0;
            if (iter_q == cfg_q.iter - 1'b1) begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end else begin
               // next period starts from the shifted base
               iter_q <= iter_q + 1'b1;
               base_q <= base_q + cfg_q.shift;
               addr_q <= base_q + cfg_q.shift;
            end
         end else begin
            step_q <= step_q + 1'b1;
            addr_q <= addr_q + cfg_q.incr;
         end
      end
   end

   a_no_valid_in_delay: assert property (@(posedge clk) disable iff (rst)
      start_i && (cfg_i.delay != '0) |=> !valid_o);

   a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
      valid_o && !ready_i && !start_i |=> valid_o && $stable(addr_o));

endmodule

// File: design/store_path.sv
`timescale 1ns/1ns
`include "vwrite_consts.svh"

module store_path
   import vwrite_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start_i,
   input  logic                  pingpong_i,
   input  logic                  bank_i,
   input  gen_cfg_t              cfg_i,
   input  logic [`VW_DATA_W-1:0] in_i,
   output buf_wr_t               wr_o,
   output logic                  done_o
);

   logic      gen_valid;
   buf_addr_u gen_addr;
   buf_addr_u wr_addr;

   // the store side never stalls
   addr_gen u_gen (
      .clk     (clk),
      .rst     (rst),
      .start_i (start_i),
      .cfg_i   (cfg_i),
      .ready_i (1'b1),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (done_o)
   );

   always_comb begin
      wr_addr = gen_addr;
      if (pingpong_i) begin
         wr_addr.banked.bank = bank_i;
      end
      wr_o.en   = gen_valid;
      wr_o.addr = wr_addr.flat;
      wr_o.data = in_i;
   end

   // generated offset must fit in one half in ping-pong mode
   a_store_bank_overflow: assert property (@(posedge clk) disable iff (rst)
      pingpong_i && gen_valid |-> !gen_addr.banked.bank);

endmodule

// File: design/drain_path.sv
`timescale 1ns/1ns
`include "vwrite_consts.svh"

module drain_path
   import vwrite_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start_i,
   input  logic                  pingpong_i,
   input  logic                  bank_i,
   input  write_cfg_t            cfg_i,
   output logic [`VW_ADDR_W-1:0] rd_addr_o,
   input  logic [`VW_DATA_W-1:0] rd_data_i,
   output wb_m2s_t               wb_o,
   input  wb_s2m_t               wb_i,
   output logic                  done_o
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_READ  = 2'd1;
   localparam logic [1:0] ST_ISSUE = 2'd2;
   localparam logic [1:0] ST_WAIT  = 2'd3;

   logic [1:0]                state_q;
   logic [`VW_LEN_W-1:0]      beat_q;
   logic [`VW_LEN_W-1:0]      len_q;
   logic [`VW_EXT_ADDR_W-1:0] ext_q;
   logic [`VW_DATA_W-1:0]     dat_q;
   logic                      done_q;
   logic                      gen_valid;
   logic                      gen_ready;
   logic                      gen_done;
   logic                      issuing;
   buf_addr_u                 gen_addr;
   buf_addr_u                 rd_addr;

   // idle also swallows addresses beyond the burst length
   assign gen_ready = (state_q == ST_READ) || (state_q == ST_IDLE);
   assign issuing = (state_q == ST_ISSUE) || (state_q == ST_WAIT);
   assign done_o = done_q;

   addr_gen u_gen (
      .clk     (clk),
      .rst     (rst),
      .start_i (start_i && cfg_i.enabled),
      .cfg_i   (cfg_i.gen),
      .ready_i (gen_ready),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (gen_done)
   );

   always_comb begin
      rd_addr = gen_addr;
      if (pingpong_i) begin
         rd_addr.banked.bank = ~bank_i;
      end
      rd_addr_o = rd_addr.flat;
      wb_o.cyc = issuing;
      wb_o.stb = issuing;
      wb_o.we  = issuing;
      wb_o.adr = ext_q + {{(`VW_EXT_ADDR_W-`VW_LEN_W-2){1'b0}}, beat_q, 2'b00};
      // read word arrives in issue and is held from the capture afterwards
      wb_o.dat = (state_q == ST_ISSUE) ? rd_data_i : dat_q;
   end

   always_ff @(posedge clk) begin
      if (start_i) begin
         ext_q <= cfg_i.ext_addr;
         len_q <= cfg_i.length;
      end
      if (state_q == ST_ISSUE) begin
         dat_q <= rd_data_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= ST_IDLE;
         beat_q  <= '0;
         done_q  <= 1'b1;
      end else if (start_i) begin
         beat_q <= '0;
         if (cfg_i.enabled && (cfg_i.length != '0)) begin
            state_q <= ST_READ;
            done_q  <= 1'b0;
         end else begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
         end
      end else begin
         case (state_q)
            ST_READ: begin
               if (gen_valid) begin
                  state_q <= ST_ISSUE;
               end else if (gen_done) begin
                  // generator ran out before the burst length
                  state_q <= ST_IDLE;
                  done_q  <= 1'b1;
               end
            end
            ST_ISSUE, ST_WAIT: begin
               if (wb_i.ack) begin
                  beat_q <= beat_q + 1'b1;
                  if (beat_q == len_q - 1'b1) begin
                     state_q <= ST_IDLE;
                     done_q  <= 1'b1;
                  end else begin
                     state_q <= ST_READ;
                  end
               end else begin
                  state_q <= ST_WAIT;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // strobe only inside a cycle and only for beats within the burst length
   a_stb_in_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_o.stb |-> wb_o.cyc && (beat_q < len_q));

   a_wb_hold: assert property (@(posedge clk) disable iff (rst)
      wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.dat));

endmodule

// File: design/vwrite_ctrl.sv
`timescale 1ns/1ns

module vwrite_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic run_i,
   input  logic pingpong_i,
   input  logic store_done_i,
   input  logic drain_done_i,
   output logic start_o,
   output logic bank_o,
   output logic done_o
);

   logic start_q;
   logic bank_q;
   logic store_flag_q;
   logic drain_flag_q;

   assign start_o = start_q;
   assign bank_o = bank_q;
   assign done_o = store_flag_q && drain_flag_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start_q      <= 1'b0;
         bank_q       <= 1'b0;
         store_flag_q <= 1'b1;
         drain_flag_q <= 1'b1;
      end else begin
         start_q <= run_i;
         // swap halves each run, plain mode stays on bank 0
         if (run_i) begin
            bank_q <= pingpong_i ? ~bank_q : 1'b0;
         end
         // path done flags still show the previous run until start has landed
         if (run_i || start_q) begin
            store_flag_q <= 1'b0;
            drain_flag_q <= 1'b0;
         end else begin
            store_flag_q <= store_flag_q || store_done_i;
            drain_flag_q <= drain_flag_q || drain_done_i;
         end
      end
   end

endmodule

// File: design/stage_buf.sv
`timescale 1ns/1ns
`include "vwrite_consts.svh"

module stage_buf
   import vwrite_pkg::*;
(
   input  logic                  clk,
   input  buf_wr_t               wr_i,
   input  logic [`VW_ADDR_W-1:0] rd_addr_i,
   output logic [`VW_DATA_W-1:0] rd_data_o
);

   localparam int DEPTH = 2 ** `VW_ADDR_W;

   logic [`VW_DATA_W-1:0] mem_q [0:DEPTH-1];

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem_q[wr_i.addr] <= wr_i.data;
      end
   end

   // registered read, old data on a same-cycle collision
   always_ff @(posedge clk) begin
      rd_data_o <= mem_q[rd_addr_i];
   end

endmodule

// File: design/vwrite_top.sv
`timescale 1ns/1ns
`include "vwrite_consts.svh"

module vwrite_top
   import vwrite_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic                  pingpong_i,
   input  gen_cfg_t              store_cfg_i,
   input  write_cfg_t            write_cfg_i,
   input  logic [`VW_DATA_W-1:0] in_i,
   input  wb_s2m_t               wb_i,
   output wb_m2s_t               wb_o,
   output logic                  done_o
);

   logic                  start;
   logic                  bank;
   logic                  store_done;
   logic                  drain_done;
   buf_wr_t               buf_wr;
   logic [`VW_ADDR_W-1:0] rd_addr;
   logic [`VW_DATA_W-1:0] rd_data;

   vwrite_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .pingpong_i   (pingpong_i),
      .store_done_i (store_done),
      .drain_done_i (drain_done),
      .start_o      (start),
      .bank_o       (bank),
      .done_o       (done_o)
   );

   store_path u_store (
      .clk        (clk),
      .rst        (rst),
      .start_i    (start),
      .pingpong_i (pingpong_i),
      .bank_i     (bank),
      .cfg_i      (store_cfg_i),
      .in_i       (in_i),
      .wr_o       (buf_wr),
      .done_o     (store_done)
   );

   // drain reads the half filled by the previous run
   drain_path u_drain (
      .clk        (clk),
      .rst        (rst),
      .start_i    (start),
      .pingpong_i (pingpong_i),
      .bank_i     (bank),
      .cfg_i      (write_cfg_i),
      .rd_addr_o  (rd_addr),
      .rd_data_i  (rd_data),
      .wb_o       (wb_o),
      .wb_i       (wb_i),
      .done_o     (drain_done)
   );

   stage_buf u_buf (
      .clk       (clk),
      .wr_i      (buf_wr),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

endmodule

// File: dv/vwrite_checker.sv
`timescale 1ns/1ns
`include "vwrite_consts.svh"

module vwrite_checker
   import vwrite_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic                  pingpong_i,
   input  gen_cfg_t              store_cfg_i,
   input  write_cfg_t            write_cfg_i,
   input  logic [`VW_DATA_W-1:0] in_i,
   input  int                    exp_beats_i,
   input  wb_m2s_t               wb_o,
   input  wb_s2m_t               wb_i,
   input  logic                  done_o,
   output int                    checks_o,
   output int                    errors_o
);

   typedef logic [`VW_ADDR_W-1:0] baddr_t;

   // model of the staging buffer contents
   logic [`VW_DATA_W-1:0] ref_mem [0:(2**`VW_ADDR_W)-1];
   baddr_t                drain_q [$];
   gen_cfg_t              st_cfg;
   write_cfg_t            wr_cfg;
   logic                  pp = 1'b0;
   logic                  bank = 1'b0;
   logic                  active = 1'b0;
   int                    ecnt = 0;
   int                    beat = 0;
   int                    model_beats = 0;
   int                    table_beats = 0;
   int                    n_chk = 0;
   int                    n_err = 0;

   assign checks_o = n_chk;
   assign errors_o = n_err;

   // start + k*shift + j*incr, wrapping at the buffer size
   function automatic baddr_t step_addr(gen_cfg_t c, int k, int j);
      return baddr_t'(int'(c.start) + k * int'(c.shift) + j * int'(c.incr));
   endfunction

   // top address bit selects the half in ping-pong mode
   function automatic baddr_t map_bank(baddr_t a, logic use_bank, logic b);
      baddr_t m;
      m = a;
      if (use_bank) begin
         m[`VW_ADDR_W-1] = b;
      end
      return m;
   endfunction

   task automatic report_error(string msg);
      n_err++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
      n_err++;
      $display("MISMATCH %s: expected 0x%08h, got 0x%08h at %0t ns", name, exp, act, $time);
   endtask

   task automatic start_run();
      int n;
      st_cfg = store_cfg_i;
      wr_cfg = write_cfg_i;
      pp = pingpong_i;
      bank = pingpong_i ? ~bank : 1'b0;
      table_beats = exp_beats_i;
      active = 1'b1;
      ecnt = 0;
      beat = 0;
      drain_q.delete();
      if (write_cfg_i.enabled) begin
         for (int k = 0; k < int'(wr_cfg.gen.iter); k++) begin
            for (int j = 0; j < int'(wr_cfg.gen.per); j++) begin
               if (j < int'(wr_cfg.gen.duty)) begin
                  drain_q.push_back(map_bank(step_addr(wr_cfg.gen, k, j), pp, ~bank));
               end
            end
         end
      end
      n = drain_q.size();
      model_beats = (n < int'(wr_cfg.length)) ? n : int'(wr_cfg.length);
   endtask

   // store step s lands on edge 2 + delay + s after the run pulse
   task automatic store_step();
      int s;
      int per;
      s = ecnt - 2 - int'(st_cfg.delay);
      per = int'(st_cfg.per);
      if (per > 0 && s >= 0 && s < per * int'(st_cfg.iter) && (s % per) < int'(st_cfg.duty)) begin
         ref_mem[map_bank(step_addr(st_cfg, s / per, s % per), pp, bank)] = in_i;
      end
   endtask

   task automatic beat_check();
      logic [`VW_EXT_ADDR_W-1:0] exp_adr;
      logic [`VW_DATA_W-1:0]     exp_dat;
      if (beat >= model_beats) begin
         report_error($sformatf("extra bus write at adr 0x%08h", wb_o.adr));
      end else begin
         exp_adr = wr_cfg.ext_addr + 4 * beat;
         exp_dat = ref_mem[drain_q[beat]];
         n_chk++;
         if (wb_o.we !== 1'b1) begin
            report_mismatch("wb_o.we", 1, wb_o.we);
         end
         if (wb_o.adr !== exp_adr) begin
            report_mismatch("wb_o.adr", exp_adr, wb_o.adr);
         end
         if (wb_o.dat !== exp_dat) begin
            report_mismatch("wb_o.dat", exp_dat, wb_o.dat);
         end
      end
      beat++;
   endtask

   task automatic done_check();
      int store_end;
      store_end = 1 + int'(st_cfg.delay) + int'(st_cfg.per) * int'(st_cfg.iter);
      if (ecnt == 1 && done_o !== 1'b0) begin
         report_error("done_o did not fall after run_i");
      end else if (done_o === 1'b1) begin
         if (ecnt <= store_end) begin
            report_error("done_o rose before the store path finished");
         end
         if (beat != table_beats) begin
            report_mismatch("burst beats", table_beats, beat);
         end
         active = 1'b0;
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         active = 1'b0;
         bank = 1'b0;
         if (done_o !== 1'b1 || wb_o.cyc !== 1'b0 || wb_o.stb !== 1'b0 ||
             wb_o.we !== 1'b0) begin
            report_error("done_o, cyc, stb or we not at reset value");
         end
      end else begin
         if (active) begin
            if (wb_o.cyc === 1'b1 && wb_o.stb === 1'b1 && wb_i.ack === 1'b1) begin
               beat_check();
            end
            ecnt++;
            store_step();
            done_check();
         end else if (wb_o.cyc === 1'b1) begin
            report_error("bus cycle while the unit is idle");
         end
         if (run_i === 1'b1) begin
            start_run();
         end
      end
   end

endmodule

// File: dv/tb_vwrite.sv
`timescale 1ns/1ns
`include "vwrite_consts.svh"

module tb_vwrite
   import vwrite_pkg::*;
();

   typedef logic [`VW_ADDR_W-1:0]  addr_t;
   typedef logic [`VW_PER_W-1:0]   per_t;
   typedef logic [`VW_DELAY_W-1:0] dly_t;
   typedef logic [`VW_LEN_W-1:0]   len_t;

   // one row per run
   typedef struct packed {
      logic                  pp;
      gen_cfg_t              store;
      write_cfg_t            wr;
      logic [`VW_DATA_W-1:0] base;
      logic [31:0]           beats;
   } run_row_t;

   localparam int NUM_RUNS = 5;

   logic                  clk;
   logic                  rst;
   logic                  run_i;
   logic                  pingpong_i;
   gen_cfg_t              store_cfg_i;
   write_cfg_t            write_cfg_i;
   logic [`VW_DATA_W-1:0] in_i;
   wb_s2m_t               wb_i;
   wb_m2s_t               wb_o;
   logic                  done_o;
   int                    exp_beats;
   int                    checks;
   int                    errors;
   run_row_t              runs [NUM_RUNS];
   logic [`VW_DATA_W-1:0] slave_mem [logic [`VW_EXT_ADDR_W-1:0]];

   vwrite_top dut (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .pingpong_i  (pingpong_i),
      .store_cfg_i (store_cfg_i),
      .write_cfg_i (write_cfg_i),
      .in_i        (in_i),
      .wb_i        (wb_i),
      .wb_o        (wb_o),
      .done_o      (done_o)
   );

   vwrite_checker chk (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .pingpong_i  (pingpong_i),
      .store_cfg_i (store_cfg_i),
      .write_cfg_i (write_cfg_i),
      .in_i        (in_i),
      .exp_beats_i (exp_beats),
      .wb_o        (wb_o),
      .wb_i        (wb_i),
      .done_o      (done_o),
      .checks_o    (checks),
      .errors_o    (errors)
   );

   function automatic gen_cfg_t make_gen(input int start, input int incr, input int per,
                                         input int duty, input int iter, input int shift,
                                         input int delay);
      gen_cfg_t g;
      g.start = addr_t'(start);
      g.incr  = addr_t'(incr);
      g.per   = per_t'(per);
      g.duty  = per_t'(duty);
      g.iter  = addr_t'(iter);
      g.shift = addr_t'(shift);
      g.delay = dly_t'(delay);
      return g;
   endfunction

   function automatic write_cfg_t make_wr(input logic [31:0] ext, input int len,
                                          input logic en, input gen_cfg_t g);
      write_cfg_t w;
      w.ext_addr = ext;
      w.length   = len_t'(len);
      w.enabled  = en;
      w.gen      = g;
      return w;
   endfunction

   task automatic fill_table();
      // plain, full drain of the words just stored
      runs[0] = '{1'b0, make_gen(0, 1, 16, 16, 1, 0, 0),
                  make_wr(32'h0000_1000, 16, 1'b1, make_gen(0, 1, 16, 16, 1, 0, 4)),
                  32'h1000_0000, 32'd16};
      // duty 3 of 6 with shift and delay, drain cut short by length
      runs[1] = '{1'b0, make_gen(0, 2, 6, 3, 4, 16, 5),
                  make_wr(32'h2000_0040, 5, 1'b1, make_gen(0, 2, 6, 6, 1, 0, 10)),
                  32'h2000_0000, 32'd5};
      // ping-pong fill only, drain off
      runs[2] = '{1'b1, make_gen(0, 1, 8, 8, 2, 8, 2),
                  make_wr(32'h3000_0000, 4, 1'b0, make_gen(0, 1, 4, 4, 1, 0, 0)),
                  32'h3300_0000, 32'd0};
      runs[3] = '{1'b1, make_gen(0, 3, 5, 4, 3, 32, 1),
                  make_wr(32'h8000_0100, 16, 1'b1, make_gen(0, 1, 16, 16, 1, 0, 0)),
                  32'h4400_0000, 32'd16};
      // drains the strided words of the previous run
      runs[4] = '{1'b1, make_gen(16, 1, 4, 2, 2, 4, 3),
                  make_wr(32'h0001_fff0, 12, 1'b1, make_gen(0, 3, 5, 4, 3, 32, 0)),
                  32'h5500_0000, 32'd12};
   endtask

   task automatic run_watchdog();
      int limit;
      limit = 16;
      for (int r = 0; r < NUM_RUNS; r++) begin
         limit += int'(runs[r].store.iter) * int'(runs[r].store.per)
                  + int'(runs[r].store.delay) + 5 * int'(runs[r].wr.length) + 20;
      end
      #(limit * 40);
      $display("watchdog expired after %0d cycles, done_o never came back", limit);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // wishbone slave memory, 0 to 3 wait cycles per beat
   initial begin
      logic                      beat_s;
      logic [`VW_EXT_ADDR_W-1:0] adr_s;
      logic [`VW_DATA_W-1:0]     dat_s;
      logic                      waiting;
      int                        wait_cnt;
      int                        seed;
      wb_i = '0;
      seed = 32'he9f4_418d;
      waiting = 1'b0;
      wait_cnt = 0;
      forever begin
         @(posedge clk);
         beat_s = wb_o.cyc && wb_o.stb && wb_i.ack;
         adr_s = wb_o.adr;
         dat_s = wb_o.dat;
         #2;
         if (beat_s) begin
            slave_mem[adr_s] = dat_s;
            wb_i.ack = 1'b0;
            waiting = 1'b0;
         end
         // zero waits acks in the first strobe cycle
         if (wb_o.cyc && wb_o.stb && !wb_i.ack) begin
            if (!waiting) begin
               wait_cnt = $random(seed) & 3;
               waiting = 1'b1;
            end
            if (wait_cnt == 0) begin
               wb_i.ack = 1'b1;
            end else begin
               wait_cnt--;
            end
         end
      end
   end

   initial begin
      int n;
      int total_beats;
      int slave_errs;
      rst = 1'b1;
      run_i = 1'b0;
      pingpong_i = 1'b0;
      store_cfg_i = '0;
      write_cfg_i = '0;
      in_i = '0;
      exp_beats = 0;
      fill_table();
      fork
         run_watchdog();
      join_none
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      repeat (2) @(posedge clk);
      for (int r = 0; r < NUM_RUNS; r++) begin
         @(posedge clk);
         #2;
         pingpong_i = runs[r].pp;
         store_cfg_i = runs[r].store;
         write_cfg_i = runs[r].wr;
         exp_beats = int'(runs[r].beats);
         in_i = runs[r].base;
         run_i = 1'b1;
         n = 0;
         // input word is base plus cycles since the run pulse
         do begin
            @(posedge clk);
            #2;
            run_i = 1'b0;
            n++;
            in_i = runs[r].base + n;
         end while (done_o !== 1'b1);
      end
      repeat (4) @(posedge clk);
      // every run writes to its own external window
      total_beats = 0;
      for (int r = 0; r < NUM_RUNS; r++) begin
         total_beats += int'(runs[r].beats);
      end
      slave_errs = 0;
      if (slave_mem.num() != total_beats) begin
         $display("ERROR: slave memory received %0d words, %0d bus writes were expected",
                  slave_mem.num(), total_beats);
         slave_errs = 1;
      end
      $display("checker: %0d bus writes compared, %0d errors", checks, errors + slave_errs);
      if (errors + slave_errs == 0 && checks > 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+design
design/vwrite_pkg.sv
design/addr_gen.sv
design/store_path.sv
design/drain_path.sv
design/vwrite_ctrl.sv
design/stage_buf.sv
design/vwrite_top.sv
dv/vwrite_checker.sv
dv/tb_vwrite.sv

// File: run_sim.sh
#!/bin/sh
# build the write-back unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_vwrite -f vlog.f -o tb_vwrite \
   > build.log 2>&1 \
   && ./obj_dir/tb_vwrite > sim.log 2>&1 \
   || echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log && echo "PASS" && exit 0 \
   || { echo "FAIL"; exit 1; }
